/* frame_patch_top.f */
logic/cfg_pkg.sv
logic/frame_buffer.sv
logic/word_counter.sv
logic/bit_flipper.sv
logic/cfg_port_seq.sv
logic/frame_ctrl_fsm.sv
logic/frame_patch_top.sv
sim/cfg_port_model.sv
sim/tb_frame_patch.sv

/* logic/bit_flipper.sv */
`timescale 1ns/1ns
`default_nettype none

module bit_flipper #(
    parameter int FRAME_WORDS = cfg_pkg::FRAME_WORDS
) (
    input  wire logic               Clk,
    input  wire logic               rst,
    input  wire logic               flip_start,
    input  wire cfg_pkg::bit_loc_t  flip_loc,
    input  wire cfg_pkg::cfg_word_t buf_rdata,
    output logic                    flip_done,
    output cfg_pkg::buf_addr_t      buf_raddr,
    output logic                    buf_we,
    output cfg_pkg::buf_addr_t      buf_waddr,
    output cfg_pkg::cfg_word_t      buf_wdata
);
    import cfg_pkg::*;

    logic [6:0] word_idx;
    logic [4:0] bit_idx;
    logic       in_range;
    cfg_word_t  mask;
    // [0] read data valid, [1] write, [2] done
    logic [2:0] stage;

    assign word_idx = flip_loc[11:5];
    assign bit_idx  = flip_loc[4:0];
    assign in_range = (int'(word_idx) < FRAME_WORDS);
    assign mask     = cfg_word_t'(1) << bit_idx;

    always_ff @(posedge Clk)
    begin
        if (rst)
            stage <= 3'b000;
        else
            stage <= {stage[1:0], flip_start};
    end

    // modified word
    always_ff @(posedge Clk)
    begin
        if (stage[0])
            buf_wdata <= buf_rdata ^ mask;
    end

    // frame sits at buffer address 0, word index is the address
    assign buf_raddr = buf_addr_t'(word_idx);
    assign buf_waddr = buf_addr_t'(word_idx);
    // past the frame end nothing is written
    assign buf_we    = stage[1] && in_range;
    assign flip_done = stage[2];

endmodule

`default_nettype wire

/* logic/cfg_pkg.sv */
`default_nettype none

package cfg_pkg;

    ////////////////////
    // data widths
    ////////////////////

    // port and buffer word
    typedef logic [31:0] cfg_word_t;
    typedef logic [31:0] frame_addr_t;
    // 512-word frame buffer
    typedef logic [8:0]  buf_addr_t;
    // 1 to 4 frames per request
    typedef logic [2:0]  frame_cnt_t;
    // [11:5] word in frame, [4:0] bit in word
    typedef logic [11:0] bit_loc_t;
    typedef logic [8:0]  word_cnt_t;

    // operation select, same values as the old start/op scheme
    typedef enum logic [2:0] {
        OP_READ  = 3'd1,
        OP_WRITE = 3'd2,
        OP_FLIP  = 3'd4
    } op_code_t;

    ////////////////////
    // frame geometry
    ////////////////////

    localparam int FRAME_WORDS = 101;
    localparam int MAX_FRAMES  = 4;

    ////////////////////
    // command words
    ////////////////////

    localparam cfg_word_t CFG_SYNC       = 32'hAA99_5566;
    localparam cfg_word_t CFG_NOOP       = 32'h2000_0000;
    // type 1 write to CMD, one word
    localparam cfg_word_t CFG_HDR_CMD    = 32'h3000_8001;
    localparam cfg_word_t CFG_CMD_RCFG   = 32'h0000_0004;
    localparam cfg_word_t CFG_CMD_WCFG   = 32'h0000_0001;
    // type 1 write to FAR, one word
    localparam cfg_word_t CFG_HDR_FAR    = 32'h3000_2001;
    // type 2 headers, word count goes in [26:0]
    localparam cfg_word_t CFG_HDR_FDRO   = 32'h4800_0000;
    localparam cfg_word_t CFG_HDR_FDRI   = 32'h5000_0000;
    localparam cfg_word_t CFG_CMD_DESYNC = 32'h0000_000D;

endpackage

`default_nettype wire

/* logic/cfg_port_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module cfg_port_seq #(
    parameter int FRAME_WORDS = cfg_pkg::FRAME_WORDS
) (
    input  wire logic                 Clk,
    input  wire logic                 rst,
    input  wire logic                 xfer_start,
    input  wire logic                 xfer_read,
    input  wire cfg_pkg::frame_addr_t xfer_addr,
    input  wire cfg_pkg::frame_cnt_t  xfer_frames,
    input  wire cfg_pkg::buf_addr_t   cnt_addr,
    input  wire logic                 cnt_last,
    input  wire cfg_pkg::cfg_word_t   cfg_rdata,
    input  wire cfg_pkg::cfg_word_t   buf_rdata,
    output logic                      xfer_done,
    output logic                      cnt_clear,
    output logic                      cnt_step,
    output logic                      cfg_csib,
    output logic                      cfg_rdwrb,
    output cfg_pkg::cfg_word_t        cfg_wdata,
    output logic                      buf_we,
    output cfg_pkg::buf_addr_t        buf_waddr,
    output cfg_pkg::cfg_word_t        buf_wdata,
    output cfg_pkg::buf_addr_t        buf_raddr
);
    import cfg_pkg::*;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PRE,
        PH_GAP_IN,
        PH_DATA,
        PH_GAP_OUT,
        PH_POST
    } phase_t;

    phase_t    phase;
    // word index within preamble or desync
    logic [2:0] idx;
    word_cnt_t data_cnt;
    cfg_word_t pre_word;
    cfg_word_t post_word;
    // readback in flight, one cycle behind the read cycle
    logic      rd_valid;
    buf_addr_t rd_addr;

    assign data_cnt = word_cnt_t'(xfer_frames * FRAME_WORDS);

    ////////////////////
    // command words
    ////////////////////

    always_comb
    begin
        case (idx)
            3'd0:    pre_word = CFG_SYNC;
            3'd1:    pre_word = CFG_NOOP;
            3'd2:    pre_word = CFG_HDR_CMD;
            3'd3:    pre_word = xfer_read ? CFG_CMD_RCFG : CFG_CMD_WCFG;
            3'd4:    pre_word = CFG_HDR_FAR;
            3'd5:    pre_word = xfer_addr;
            // type 2 header with the data word count
            3'd6:    pre_word = (xfer_read ? CFG_HDR_FDRO : CFG_HDR_FDRI)
                                | cfg_word_t'(data_cnt);
            default: pre_word = CFG_NOOP;
        endcase
    end

    assign post_word = idx[0] ? CFG_CMD_DESYNC : CFG_HDR_CMD;

    ////////////////////
    // phase register
    ////////////////////

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            phase     <= PH_IDLE;
            idx       <= 3'd0;
            xfer_done <= 1'b0;
            rd_valid  <= 1'b0;
        end
        else
        begin
            xfer_done <= 1'b0;
            rd_valid  <= (phase == PH_DATA) && xfer_read;
            case (phase)
                PH_IDLE:
                begin
                    if (xfer_start)
                    begin
                        phase <= PH_PRE;
                        idx   <= 3'd0;
                    end
                end
                PH_PRE:
                begin
                    if (idx == 3'd6)
                    begin
                        idx   <= 3'd0;
                        phase <= xfer_read ? PH_GAP_IN : PH_DATA;
                    end
                    else
                        idx <= idx + 3'd1;
                end
                // rdwrb turns around here with csib high
                PH_GAP_IN: phase <= PH_DATA;
                PH_DATA:
                begin
                    if (cnt_last)
                        phase <= xfer_read ? PH_GAP_OUT : PH_POST;
                end
                PH_GAP_OUT: phase <= PH_POST;
                PH_POST:
                begin
                    if (idx == 3'd1)
                    begin
                        phase     <= PH_IDLE;
                        xfer_done <= 1'b1;
                    end
                    else
                        idx <= idx + 3'd1;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // buffer address of the word coming back next cycle
    always_ff @(posedge Clk)
    begin
        rd_addr <= cnt_addr;
    end

    ////////////////////
    // port drive
    ////////////////////

    always_comb
    begin
        cfg_csib  = 1'b1;
        cfg_rdwrb = 1'b0;
        cfg_wdata = CFG_NOOP;
        case (phase)
            PH_PRE:
            begin
                cfg_csib  = 1'b0;
                cfg_wdata = pre_word;
            end
            PH_GAP_IN: cfg_rdwrb = 1'b1;
            PH_DATA:
            begin
                cfg_csib  = 1'b0;
                cfg_rdwrb = xfer_read;
                cfg_wdata = buf_rdata;
            end
            PH_POST:
            begin
                cfg_csib  = 1'b0;
                cfg_wdata = post_word;
            end
            default: cfg_csib = 1'b1;
        endcase
    end

    // counter holds at zero between transfers
    assign cnt_clear = (phase == PH_IDLE);
    assign cnt_step  = (phase == PH_DATA);

    // prefetch next word while the current one is on the port
    assign buf_raddr = (phase == PH_DATA) ? buf_addr_t'(cnt_addr + 9'd1) : cnt_addr;

    assign buf_we    = rd_valid;
    assign buf_waddr = rd_addr;
    assign buf_wdata = cfg_rdata;

endmodule

`default_nettype wire

/* logic/frame_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_buffer (
    input  wire logic               Clk,
    input  wire logic               we,
    input  wire cfg_pkg::buf_addr_t waddr,
    input  wire cfg_pkg::cfg_word_t wdata,
    input  wire cfg_pkg::buf_addr_t raddr,
    output cfg_pkg::cfg_word_t      rdata
);
    import cfg_pkg::*;

    // room for four frames plus slack
    cfg_word_t mem [0:511];

    // simple dual port, read data one cycle after address
    always_ff @(posedge Clk)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* logic/frame_ctrl_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_ctrl_fsm (
    input  wire logic                 Clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire cfg_pkg::op_code_t    op_sel,
    input  wire cfg_pkg::frame_addr_t frame_addr,
    input  wire cfg_pkg::frame_cnt_t  num_frames,
    input  wire cfg_pkg::bit_loc_t    bit_location,
    input  wire logic                 xfer_done,
    input  wire logic                 flip_done,
    output logic                      busy,
    output logic                      done,
    output logic                      xfer_start,
    output logic                      xfer_read,
    output cfg_pkg::frame_addr_t      xfer_addr,
    output cfg_pkg::frame_cnt_t       xfer_frames,
    output logic                      flip_start,
    output cfg_pkg::bit_loc_t         flip_loc,
    output logic                      flip_active
);
    import cfg_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WRITE,
        FLIP_READ,
        FLIP_MODIFY,
        FLIP_WRITE,
        FINISH
    } state_t;

    state_t state;

    // start is only looked at in IDLE, so busy doubles as the lockout
    assign busy        = (state != IDLE);
    assign flip_active = (state == FLIP_MODIFY);

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state      <= IDLE;
            done       <= 1'b0;
            xfer_start <= 1'b0;
            xfer_read  <= 1'b0;
            flip_start <= 1'b0;
        end
        else
        begin
            // strobes default low
            done       <= 1'b0;
            xfer_start <= 1'b0;
            flip_start <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        xfer_addr   <= frame_addr;
                        xfer_frames <= num_frames;
                        flip_loc    <= bit_location;
                        case (op_sel)
                            OP_READ:
                            begin
                                state      <= READ;
                                xfer_read  <= 1'b1;
                                xfer_start <= 1'b1;
                            end
                            OP_WRITE:
                            begin
                                state      <= WRITE;
                                xfer_read  <= 1'b0;
                                xfer_start <= 1'b1;
                            end
                            OP_FLIP:
                            begin
                                // flip always works on one frame
                                state       <= FLIP_READ;
                                xfer_frames <= frame_cnt_t'(1);
                                xfer_read   <= 1'b1;
                                xfer_start  <= 1'b1;
                            end
                            // unknown op, finish without port traffic
                            default: state <= FINISH;
                        endcase
                    end
                end
                READ, WRITE, FLIP_WRITE:
                begin
                    if (xfer_done)
                        state <= FINISH;
                end
                FLIP_READ:
                begin
                    if (xfer_done)
                    begin
                        state      <= FLIP_MODIFY;
                        flip_start <= 1'b1;
                    end
                end
                FLIP_MODIFY:
                begin
                    // write back to the same frame address
                    if (flip_done)
                    begin
                        state      <= FLIP_WRITE;
                        xfer_read  <= 1'b0;
                        xfer_start <= 1'b1;
                    end
                end
                FINISH:
                begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/frame_patch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_patch_top #(
    parameter int FRAME_WORDS = cfg_pkg::FRAME_WORDS
) (
    input  wire logic                 Clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire cfg_pkg::op_code_t    op_sel,
    input  wire cfg_pkg::frame_addr_t frame_addr,
    input  wire cfg_pkg::frame_cnt_t  num_frames,
    input  wire cfg_pkg::bit_loc_t    bit_location,
    output logic                      busy,
    output logic                      done,
    output logic                      cfg_csib,
    output logic                      cfg_rdwrb,
    output cfg_pkg::cfg_word_t        cfg_wdata,
    input  wire cfg_pkg::cfg_word_t   cfg_rdata
);
    import cfg_pkg::*;

    // fsm to sequencer
    logic        xfer_start;
    logic        xfer_read;
    logic        xfer_done;
    frame_addr_t xfer_addr;
    frame_cnt_t  xfer_frames;

    // fsm to flipper
    logic        flip_start;
    logic        flip_done;
    logic        flip_active;
    bit_loc_t    flip_loc;

    // word counter
    logic        cnt_clear;
    logic        cnt_step;
    logic        cnt_last;
    buf_addr_t   cnt_addr;

    // buffer ports, one set per owner
    logic        seq_we;
    buf_addr_t   seq_waddr;
    cfg_word_t   seq_wdata;
    buf_addr_t   seq_raddr;
    logic        flip_we;
    buf_addr_t   flip_waddr;
    cfg_word_t   flip_wdata;
    buf_addr_t   flip_raddr;
    logic        buf_we;
    buf_addr_t   buf_waddr;
    cfg_word_t   buf_wdata;
    buf_addr_t   buf_raddr;
    cfg_word_t   buf_rdata;

    ////////////////////
    // buffer owner select
    ////////////////////

    // flipper owns both ports only while modifying
    assign buf_we    = flip_active ? flip_we    : seq_we;
    assign buf_waddr = flip_active ? flip_waddr : seq_waddr;
    assign buf_wdata = flip_active ? flip_wdata : seq_wdata;
    assign buf_raddr = flip_active ? flip_raddr : seq_raddr;

    frame_ctrl_fsm u_ctrl (
        .Clk(Clk), .rst(rst), .start(start), .op_sel(op_sel),
        .frame_addr(frame_addr), .num_frames(num_frames), .bit_location(bit_location),
        .xfer_done(xfer_done), .flip_done(flip_done),
        .busy(busy), .done(done), .xfer_start(xfer_start), .xfer_read(xfer_read),
        .xfer_addr(xfer_addr), .xfer_frames(xfer_frames), .flip_start(flip_start),
        .flip_loc(flip_loc), .flip_active(flip_active)
    );

    cfg_port_seq #(.FRAME_WORDS(FRAME_WORDS)) u_seq (
        .Clk(Clk), .rst(rst), .xfer_start(xfer_start), .xfer_read(xfer_read),
        .xfer_addr(xfer_addr), .xfer_frames(xfer_frames),
        .cnt_addr(cnt_addr), .cnt_last(cnt_last),
        .cfg_rdata(cfg_rdata), .buf_rdata(buf_rdata),
        .xfer_done(xfer_done), .cnt_clear(cnt_clear), .cnt_step(cnt_step),
        .cfg_csib(cfg_csib), .cfg_rdwrb(cfg_rdwrb), .cfg_wdata(cfg_wdata),
        .buf_we(seq_we), .buf_waddr(seq_waddr), .buf_wdata(seq_wdata),
        .buf_raddr(seq_raddr)
    );

    word_counter #(.FRAME_WORDS(FRAME_WORDS)) u_cnt (
        .Clk(Clk), .rst(rst), .cnt_clear(cnt_clear), .cnt_step(cnt_step),
        .cnt_frames(xfer_frames), .cnt_addr(cnt_addr), .cnt_last(cnt_last)
    );

    frame_buffer u_buf (
        .Clk(Clk), .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
        .raddr(buf_raddr), .rdata(buf_rdata)
    );

    bit_flipper #(.FRAME_WORDS(FRAME_WORDS)) u_flip (
        .Clk(Clk), .rst(rst), .flip_start(flip_start), .flip_loc(flip_loc),
        .buf_rdata(buf_rdata), .flip_done(flip_done), .buf_raddr(flip_raddr),
        .buf_we(flip_we), .buf_waddr(flip_waddr), .buf_wdata(flip_wdata)
    );

endmodule

`default_nettype wire

/* logic/word_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module word_counter #(
    parameter int FRAME_WORDS = cfg_pkg::FRAME_WORDS
) (
    input  wire logic                Clk,
    input  wire logic                rst,
    input  wire logic                cnt_clear,
    input  wire logic                cnt_step,
    input  wire cfg_pkg::frame_cnt_t cnt_frames,
    output cfg_pkg::buf_addr_t       cnt_addr,
    output logic                     cnt_last
);
    import cfg_pkg::*;

    // last word index of the whole span
    word_cnt_t term;

    assign term = word_cnt_t'(cnt_frames * FRAME_WORDS - 1);

    always_ff @(posedge Clk)
    begin
        if (rst)
            cnt_addr <= '0;
        else if (cnt_clear)
            cnt_addr <= '0;
        else if (cnt_step)
            cnt_addr <= cnt_addr + 9'd1;
    end

    assign cnt_last = (word_cnt_t'(cnt_addr) == term);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_frame_patch -f frame_patch_top.f
./obj_dir/Vtb_frame_patch > sim.log 2>&1
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

/* sim/cfg_port_model.sv */
`timescale 1ns/1ns
`default_nettype none

module cfg_port_model (
    input  wire logic               Clk,
    input  wire logic               rst,
    input  wire logic               cfg_csib,
    input  wire logic               cfg_rdwrb,
    input  wire cfg_pkg::cfg_word_t cfg_wdata,
    output cfg_pkg::cfg_word_t      cfg_rdata
);
    import cfg_pkg::*;

    localparam int NUM_FRAMES = 16;
    localparam int MEM_WORDS  = NUM_FRAMES * FRAME_WORDS;

    // frame f starts at f * FRAME_WORDS
    cfg_word_t   mem [0:MEM_WORDS-1];

    ////////////////////
    // decoder state
    ////////////////////

    logic        synced;
    // next word is a command or a frame address
    logic        want_cmd;
    logic        want_far;
    logic        rd_mode;
    logic        is_fdro;
    // port pins seen at the previous edge
    logic        last_csib;
    logic        last_rdwrb;
    // data words still expected in this phase
    int          remain;
    int          ptr;
    int          count;
    frame_addr_t far;
    // counters the testbench looks at
    int          proto_err;
    int          xfers;
    int          port_cycles;

    task automatic report_protocol_error(input string what);
        proto_err++;
        $display("port model error at %0t: %s", $time, what);
    endtask

    always @(posedge Clk)
    begin
        if (rst)
        begin
            synced      = 1'b0;
            want_cmd    = 1'b0;
            want_far    = 1'b0;
            rd_mode     = 1'b0;
            last_csib   = 1'b1;
            last_rdwrb  = 1'b0;
            remain      = 0;
            ptr         = 0;
            far         = '0;
            proto_err   = 0;
            xfers       = 0;
            port_cycles = 0;
            cfg_rdata   <= '0;
        end
        else
        begin
            // rdwrb turns around only with csib high
            if (!cfg_csib && !last_csib && cfg_rdwrb != last_rdwrb)
                report_protocol_error("rdwrb changed while the port was enabled");
            last_csib  = cfg_csib;
            last_rdwrb = cfg_rdwrb;
        end
        if (!rst && !cfg_csib)
        begin
            port_cycles++;
            if (cfg_rdwrb)
            begin
                // readback word shows up next cycle
                if (remain == 0 || !rd_mode)
                    report_protocol_error("read cycle outside a readback data phase");
                else
                begin
                    cfg_rdata <= mem[ptr];
                    ptr++;
                    remain--;
                end
            end
            else if (!synced)
            begin
                if (cfg_wdata == CFG_SYNC)
                    synced = 1'b1;
                else
                    report_protocol_error("data word arrived before the sync word");
            end
            else if (remain != 0)
            begin
                if (rd_mode)
                    report_protocol_error("write cycle inside a readback data phase");
                else
                begin
                    mem[ptr] = cfg_wdata;
                    ptr++;
                    remain--;
                end
            end
            else if (want_cmd)
            begin
                want_cmd = 1'b0;
                if (cfg_wdata == CFG_CMD_RCFG)
                    rd_mode = 1'b1;
                else if (cfg_wdata == CFG_CMD_WCFG)
                    rd_mode = 1'b0;
                else if (cfg_wdata == CFG_CMD_DESYNC)
                begin
                    synced = 1'b0;
                    xfers++;
                end
            end
            else if (want_far)
            begin
                want_far = 1'b0;
                far      = cfg_wdata;
            end
            else if (cfg_wdata == CFG_HDR_CMD)
                want_cmd = 1'b1;
            else if (cfg_wdata == CFG_HDR_FAR)
                want_far = 1'b1;
            else if ((cfg_wdata & 32'hF800_0000) == CFG_HDR_FDRO ||
                     (cfg_wdata & 32'hF800_0000) == CFG_HDR_FDRI)
            begin
                // type 2 header opens the data phase
                is_fdro = ((cfg_wdata & 32'hF800_0000) == CFG_HDR_FDRO);
                count   = int'(cfg_wdata[26:0]);
                if (count == 0 || count > MAX_FRAMES * FRAME_WORDS)
                    report_protocol_error("word count runs past four frames");
                else if (count % FRAME_WORDS != 0)
                    report_protocol_error("word count is not a whole number of frames");
                else if (is_fdro != rd_mode)
                    report_protocol_error("data header does not match the command");
                else if (far >= frame_addr_t'(NUM_FRAMES) ||
                         int'(far) * FRAME_WORDS + count > MEM_WORDS)
                    report_protocol_error("transfer reaches past the model memory");
                else
                begin
                    ptr    = int'(far) * FRAME_WORDS;
                    remain = count;
                end
            end
            // only noop may stand between commands
            else if (cfg_wdata != CFG_NOOP)
                report_protocol_error("unexpected word outside a data phase");
        end
    end

endmodule

`default_nettype wire

/* sim/tb_frame_patch.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_frame_patch;
    import cfg_pkg::*;

    localparam int NUM_FRAMES   = 16;
    localparam int MEM_WORDS    = NUM_FRAMES * FRAME_WORDS;
    localparam int NUM_TESTS    = 11;
    localparam int DONE_TIMEOUT = 5000;
    localparam int QUIET_CYCLES = 20;

    ////////////////////
    // kinds of expected result
    ////////////////////

    // memory unchanged, keep a copy of the frames read
    localparam logic [2:0] K_READ     = 3'd0;
    // target frames take the kept copy
    localparam logic [2:0] K_WRITE    = 3'd1;
    localparam logic [2:0] K_FLIP     = 3'd2;
    // word index past the frame, memory unchanged
    localparam logic [2:0] K_FLIP_OOR = 3'd3;
    // unknown op, no port traffic at all
    localparam logic [2:0] K_NOP      = 3'd4;
    // read with a second start while busy
    localparam logic [2:0] K_RETRIG   = 3'd5;

    typedef struct packed {
        logic [2:0]  op;
        frame_addr_t addr;
        frame_cnt_t  frames;
        bit_loc_t    loc;
        logic [2:0]  kind;
    } test_row_t;

    // op, frame address, frames, bit location, kind
    test_row_t tests [0:NUM_TESTS-1] = '{
        '{3'd1, 32'd2,  3'd1, 12'd0,           K_READ},
        '{3'd2, 32'd9,  3'd1, 12'd0,           K_WRITE},
        '{3'd1, 32'd4,  3'd4, 12'd0,           K_READ},
        '{3'd2, 32'd10, 3'd4, 12'd0,           K_WRITE},
        '{3'd4, 32'd3,  3'd1, {7'd37, 5'd19},  K_FLIP},
        '{3'd4, 32'd15, 3'd1, {7'd0, 5'd0},    K_FLIP},
        '{3'd4, 32'd5,  3'd1, {7'd100, 5'd31}, K_FLIP},
        '{3'd4, 32'd8,  3'd1, {7'd101, 5'd4},  K_FLIP_OOR},
        '{3'd2, 32'd11, 3'd2, 12'd0,           K_WRITE},
        '{3'd3, 32'd6,  3'd1, 12'd0,           K_NOP},
        '{3'd1, 32'd1,  3'd2, 12'd0,           K_RETRIG}
    };

    logic        Clk = 1'b0;
    logic        rst;
    logic        start;
    op_code_t    op_sel;
    frame_addr_t frame_addr;
    frame_cnt_t  num_frames;
    bit_loc_t    bit_location;
    logic        busy;
    logic        done;
    logic        cfg_csib;
    logic        cfg_rdwrb;
    cfg_word_t   cfg_wdata;
    cfg_word_t   cfg_rdata;

    // expected model image and the frames held in the DUT buffer
    cfg_word_t   exp_mem [0:MEM_WORDS-1];
    cfg_word_t   copy_buf [0:MAX_FRAMES*FRAME_WORDS-1];
    int          errors;
    int          tests_run;
    bit          timed_out;

    always #50 Clk = ~Clk;

    frame_patch_top DUT (
        .Clk(Clk), .rst(rst), .start(start), .op_sel(op_sel),
        .frame_addr(frame_addr), .num_frames(num_frames), .bit_location(bit_location),
        .busy(busy), .done(done), .cfg_csib(cfg_csib), .cfg_rdwrb(cfg_rdwrb),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    cfg_port_model u_model (
        .Clk(Clk), .rst(rst), .cfg_csib(cfg_csib), .cfg_rdwrb(cfg_rdwrb),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic wait_done(output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < DONE_TIMEOUT && !seen; n++)
        begin
            @(negedge Clk);
            if (done)
                seen = 1'b1;
        end
    endtask

    ////////////////////
    // one table row
    ////////////////////

    task automatic run_test(input int t);
        test_row_t row;
        int        err_before;
        int        err_model;
        int        xfer_before;
        int        cycle_before;
        int        exp_xfers;
        int        base;
        int        n_words;
        int        word;
        int        extra_done;
        int        i;
        bit        seen;

        row          = tests[t];
        err_before   = errors;
        err_model    = u_model.proto_err;
        xfer_before  = u_model.xfers;
        cycle_before = u_model.port_cycles;
        base         = int'(row.addr) * FRAME_WORDS;
        n_words      = int'(row.frames) * FRAME_WORDS;
        word         = int'(row.loc[11:5]);

        for (i = 0; i < MEM_WORDS; i++)
            exp_mem[i] = u_model.mem[i];
        case (row.kind)
            K_READ, K_RETRIG:
            begin
                for (i = 0; i < n_words; i++)
                    copy_buf[i] = exp_mem[base + i];
            end
            K_WRITE:
            begin
                for (i = 0; i < n_words; i++)
                    exp_mem[base + i] = copy_buf[i];
            end
            K_FLIP, K_FLIP_OOR:
            begin
                // one bit of one word inverted
                if (row.kind == K_FLIP)
                    exp_mem[base + word] = exp_mem[base + word]
                                           ^ (cfg_word_t'(1) << row.loc[4:0]);
                // buffer now starts with the target frame
                for (i = 0; i < n_words; i++)
                    copy_buf[i] = exp_mem[base + i];
            end
            default: ;
        endcase

        // flip is a read plus a write back
        if (row.kind == K_NOP)
            exp_xfers = 0;
        else if (row.kind == K_FLIP || row.kind == K_FLIP_OOR)
            exp_xfers = 2;
        else
            exp_xfers = 1;

        @(posedge Clk);
        start        <= 1'b1;
        op_sel       <= op_code_t'(row.op);
        frame_addr   <= row.addr;
        num_frames   <= row.frames;
        bit_location <= row.loc;
        @(posedge Clk);
        if (row.kind == K_RETRIG)
        begin
            // this one lands while busy and has to be dropped
            op_sel     <= OP_WRITE;
            frame_addr <= 32'd14;
            @(negedge Clk);
            check_value("busy", 32'(busy), 1);
            @(posedge Clk);
        end
        start <= 1'b0;

        wait_done(seen);
        if (!seen)
        begin
            $display("test %0d: done did not arrive within %0d cycles", t, DONE_TIMEOUT);
            timed_out = 1'b1;
        end
        else
        begin
            // watch for a second done
            extra_done = 0;
            repeat (QUIET_CYCLES)
            begin
                @(negedge Clk);
                if (done)
                    extra_done++;
            end
            check_value("extra_done", extra_done, 0);
            check_value("busy", 32'(busy), 0);
            check_value("proto_err", u_model.proto_err, err_model);
            check_value("transfers", u_model.xfers - xfer_before, exp_xfers);
            if (exp_xfers > 0)
                check_value("far", u_model.far, row.addr);
            else
                check_value("port_cycles", u_model.port_cycles - cycle_before, 0);
            for (i = 0; i < MEM_WORDS; i++)
                check_value($sformatf("frame%0d.word%0d", i / FRAME_WORDS, i % FRAME_WORDS),
                            u_model.mem[i], exp_mem[i]);
            $display("test %0d kind %0d frame %0d: %s", t, row.kind, row.addr,
                     (errors == err_before) ? "ok" : "mismatch");
        end
        tests_run++;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        int i;
        int t;
        errors       = 0;
        tests_run    = 0;
        timed_out    = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        op_sel       = OP_READ;
        frame_addr   = '0;
        num_frames   = 3'd1;
        bit_location = '0;
        void'($urandom(32'h8ec5));
        // random frame contents
        for (i = 0; i < MEM_WORDS; i++)
            u_model.mem[i] = $urandom;

        repeat (4) @(posedge Clk);
        rst <= 1'b0;
        @(negedge Clk);
        check_value("busy", 32'(busy), 0);
        check_value("done", 32'(done), 0);
        check_value("cfg_csib", 32'(cfg_csib), 1);
        $display("reset: %s", (errors == 0) ? "ok" : "mismatch");

        for (t = 0; t < NUM_TESTS && !timed_out; t++)
            run_test(t);

        $display("tests run %0d of %0d, errors %0d", tests_run, NUM_TESTS, errors);
        if (errors == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
